//--- all.f
maze_pkg.sv
cmd_decode.sv
motion_animator.sv
pose_commit.sv
maze_nav_top.sv
maze_nav_assert.sv
tb_maze_nav.sv

//--- tb_maze_nav.sv
`timescale 1ns/1ps

module tb_maze_nav import maze_pkg::*; ();

    localparam int UNIT_SIZE   = 8;
    localparam int NUM_CMDS    = 60;
    localparam int CYCLE_LIMIT = NUM_CMDS * (TURN_STEPS + 20) + 100;

    typedef struct packed {
        logic       accepted;
        cell_t      row;
        cell_t      col;
        heading_t   head;
        angle_t     ang;
        logic [7:0] steps;
    } expect_t;

    logic     clk_in;
    logic     reset_btn;
    logic     cmd_req;
    cmd_t     cmd;
    logic     cmd_ack;
    logic     cmd_accepted;
    logic     busy;
    cell_t    cell_row;
    cell_t    cell_col;
    heading_t heading;
    coord_t   center_x;
    coord_t   center_y;
    angle_t   angle;

    expect_t     expect_q[$];
    cell_t       m_row;
    cell_t       m_col;
    heading_t    m_head;
    int          m_ang;
    logic [31:0] rng_state;
    int          busy_cycles  = 0;
    int          acks_checked = 0;
    int          cycle_count  = 0;
    logic        ack_prev     = 1'b0;
    logic        req_at_edge  = 1'b0;

    maze_nav_top #(
        .UNIT_SIZE (UNIT_SIZE)
    ) i_dut (
        .clk_in       (clk_in),
        .reset_btn    (reset_btn),
        .cmd_req      (cmd_req),
        .cmd          (cmd),
        .cmd_ack      (cmd_ack),
        .cmd_accepted (cmd_accepted),
        .busy         (busy),
        .cell_row     (cell_row),
        .cell_col     (cell_col),
        .heading      (heading),
        .center_x     (center_x),
        .center_y     (center_y),
        .angle        (angle)
    );

    bind maze_nav_top maze_nav_assert i_nav_assert (
        .clk_in    (clk_in),
        .reset_btn (reset_btn),
        .cmd_req   (cmd_req),
        .cmd_ack   (cmd_ack),
        .busy      (busy),
        .cell_row  (cell_row),
        .cell_col  (cell_col),
        .heading   (heading)
    );

    always #4 clk_in = ~clk_in;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // maze rows with the leftmost digit as column 4
    function automatic logic wall_at(input int r, input int c);
        logic [4:0] bits;
        case (r)
            0:       bits = 5'b00010;
            4:       bits = 5'b01000;
            default: bits = 5'b01010;
        endcase
        return bits[c];
    endfunction

    function automatic heading_t turn_left_of(input heading_t h);
        case (h)
            HEAD_U:  return HEAD_L;
            HEAD_L:  return HEAD_D;
            HEAD_D:  return HEAD_R;
            default: return HEAD_U;
        endcase
    endfunction

    function automatic heading_t turn_right_of(input heading_t h);
        case (h)
            HEAD_U:  return HEAD_R;
            HEAD_R:  return HEAD_D;
            HEAD_D:  return HEAD_L;
            default: return HEAD_U;
        endcase
    endfunction

    // reference model for acceptance and next pose of one command
    function automatic logic predict_cmd(
        input  cmd_t     c,
        input  cell_t    row,
        input  cell_t    col,
        input  heading_t head,
        input  int       ang,
        output cell_t    next_row,
        output cell_t    next_col,
        output heading_t next_head,
        output int       next_ang
    );
        int   tr;
        int   tc;
        logic ok;
        next_row  = row;
        next_col  = col;
        next_head = head;
        next_ang  = ang;
        ok        = 1'b0;
        tr        = int'(row);
        tc        = int'(col);
        case (c)
            CMD_MOVE: begin
                case (head)
                    HEAD_U:  tr = tr - 1;
                    HEAD_D:  tr = tr + 1;
                    HEAD_L:  tc = tc - 1;
                    default: tc = tc + 1;
                endcase
                if (tr >= 0 && tr < GRID_DIM && tc >= 0 && tc < GRID_DIM) begin
                    if (!wall_at(tr, tc)) begin
                        ok       = 1'b1;
                        next_row = cell_t'(tr);
                        next_col = cell_t'(tc);
                    end
                end
            end
            CMD_LEFT: begin
                ok        = 1'b1;
                next_head = turn_left_of(head);
                next_ang  = (ang + 270) % 360;
            end
            CMD_RIGHT: begin
                ok        = 1'b1;
                next_head = turn_right_of(head);
                next_ang  = (ang + 90) % 360;
            end
            default: ok = 1'b0;
        endcase
        return ok;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("FAILED at %0d ns: %s", $time, msg));
    endtask

    task automatic check_reset_state();
        assert (!cmd_ack && !cmd_accepted && !busy)
        else report_mismatch("handshake outputs not low after reset");
        assert (cell_row == 3'd0 && cell_col == 3'd0 && heading == HEAD_U)
        else report_mismatch($sformatf("reset pose row %0d col %0d heading %s",
                                       cell_row, cell_col, heading.name()));
        assert (int'(center_x) == UNIT_SIZE / 2 && int'(center_y) == UNIT_SIZE / 2)
        else report_mismatch($sformatf("reset centre %0d,%0d", center_x, center_y));
        assert (int'(angle) == ANGLE_START)
        else report_mismatch($sformatf("reset angle %0d", angle));
    endtask

    // one full four-phase transaction started on a falling edge
    task automatic issue_command(input cmd_t c, input int hold, input int idle);
        expect_t  e;
        cell_t    nr;
        cell_t    nc;
        heading_t nh;
        int       na;
        logic     ok;
        ok = predict_cmd(c, m_row, m_col, m_head, m_ang, nr, nc, nh, na);
        e.accepted = ok;
        e.row      = nr;
        e.col      = nc;
        e.head     = nh;
        e.ang      = angle_t'(na);
        e.steps    = !ok ? 8'd0 : (c == CMD_MOVE ? 8'(UNIT_SIZE) : 8'(TURN_STEPS));
        expect_q.push_back(e);
        m_row   = nr;
        m_col   = nc;
        m_head  = nh;
        m_ang   = na;
        cmd     = c;
        cmd_req = 1'b1;
        do @(negedge clk_in); while (!cmd_ack);
        // keep the request up a while to exercise back-pressure
        repeat (hold) @(negedge clk_in);
        cmd_req = 1'b0;
        do @(negedge clk_in); while (cmd_ack);
        repeat (idle) @(negedge clk_in);
    endtask

    always @(posedge clk_in) begin
        req_at_edge <= cmd_req;
    end

    always @(posedge clk_in) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            abort_run($sformatf("timeout: cmd_ack never arrived within %0d cycles",
                                CYCLE_LIMIT));
        end
    end

    always @(negedge clk_in) begin : compare_outputs
        expect_t e;
        int      exp_x;
        int      exp_y;
        if (i_dut.i_nav_assert.failures != 0) begin
            abort_run("a bound handshake or pose assertion failed");
        end
        if (busy && !cmd_ack) begin
            busy_cycles = busy_cycles + 1;
        end
        if (cmd_ack) begin
            assert (!busy) else report_mismatch("busy high while cmd_ack is high");
        end
        if (ack_prev && req_at_edge) begin
            assert (cmd_ack) else report_mismatch("cmd_ack dropped while cmd_req held high");
        end
        if (cmd_ack && !ack_prev) begin
            if (expect_q.size() == 0) begin
                abort_run("cmd_ack rose with no command outstanding");
            end else begin
                e     = expect_q.pop_front();
                exp_x = int'(e.row) * UNIT_SIZE + UNIT_SIZE / 2;
                exp_y = int'(e.col) * UNIT_SIZE + UNIT_SIZE / 2;
                assert (cmd_accepted == e.accepted)
                else report_mismatch($sformatf("cmd_accepted %0b, expected %0b",
                                               cmd_accepted, e.accepted));
                assert (cell_row == e.row && cell_col == e.col)
                else report_mismatch($sformatf("cell %0d,%0d, expected %0d,%0d",
                                               cell_row, cell_col, e.row, e.col));
                assert (heading == e.head)
                else report_mismatch($sformatf("heading %s, expected %s",
                                               heading.name(), e.head.name()));
                assert (int'(center_x) == exp_x && int'(center_y) == exp_y)
                else report_mismatch($sformatf("centre %0d,%0d, expected %0d,%0d",
                                               center_x, center_y, exp_x, exp_y));
                assert (angle == e.ang)
                else report_mismatch($sformatf("angle %0d, expected %0d", angle, e.ang));
                // animation length shows up as busy time
                if (e.steps == 8'd0) begin
                    assert (busy_cycles == 0)
                    else report_mismatch($sformatf("busy for %0d cycles on a rejected command",
                                                   busy_cycles));
                end else begin
                    assert (busy_cycles >= int'(e.steps))
                    else report_mismatch($sformatf("busy for %0d cycles, expected at least %0d",
                                                   busy_cycles, e.steps));
                end
                busy_cycles  = 0;
                acks_checked = acks_checked + 1;
            end
        end
        ack_prev = cmd_ack;
    end

    initial begin
        cmd_t c;
        int   hold;
        int   idle;
        clk_in    = 1'b0;
        reset_btn = 1'b1;
        cmd_req   = 1'b0;
        cmd       = CMD_NONE;
        m_row     = 3'd0;
        m_col     = 3'd0;
        m_head    = HEAD_U;
        m_ang     = ANGLE_START;
        rng_state = 32'd92;
        repeat (16) @(posedge clk_in);
        @(negedge clk_in);
        reset_btn = 1'b0;
        @(negedge clk_in);
        check_reset_state();
        // grid edges, a wall, a no-op and one legal step
        issue_command(CMD_MOVE, 0, 1);
        issue_command(CMD_LEFT, 2, 0);
        issue_command(CMD_MOVE, 1, 2);
        issue_command(CMD_RIGHT, 0, 0);
        issue_command(CMD_RIGHT, 3, 1);
        issue_command(CMD_MOVE, 0, 0);
        issue_command(CMD_NONE, 2, 1);
        issue_command(CMD_RIGHT, 0, 2);
        issue_command(CMD_MOVE, 1, 0);
        for (int n = 9; n < NUM_CMDS; n++) begin
            rng_state = xorshift32(rng_state);
            case (rng_state[2:0])
                3'd0:       c = CMD_NONE;
                3'd5:       c = CMD_LEFT;
                3'd6, 3'd7: c = CMD_RIGHT;
                default:    c = CMD_MOVE;
            endcase
            hold = int'(rng_state[9:8]);
            idle = int'(rng_state[13:12]);
            issue_command(c, hold, idle);
        end
        repeat (4) @(negedge clk_in);
        if (acks_checked == NUM_CMDS && expect_q.size() == 0 &&
            i_dut.i_nav_assert.failures == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort_run("not every command was acknowledged and checked");
        end
    end

endmodule

//--- maze_nav_assert.sv
`timescale 1ns/1ps

module maze_nav_assert import maze_pkg::*; (
    input logic     clk_in,
    input logic     reset_btn,
    input logic     cmd_req,
    input logic     cmd_ack,
    input logic     busy,
    input cell_t    cell_row,
    input cell_t    cell_col,
    input heading_t heading
);

    // failure counts, one per property
    int unsigned n_ack_rise = 0;
    int unsigned n_ack_fall = 0;
    int unsigned n_pose     = 0;
    int unsigned n_busy     = 0;
    int unsigned failures;

    assign failures = n_ack_rise + n_ack_fall + n_pose + n_busy;

    // ack answers a request the DUT has sampled
    ack_rise_chk: assert property (@(posedge clk_in) disable iff (reset_btn)
        $rose(cmd_ack) |-> $past(cmd_req))
    else begin
        $error("cmd_ack rose without cmd_req high");
        n_ack_rise++;
    end

    // two samples of a low request leave no ack behind
    ack_fall_chk: assert property (@(posedge clk_in) disable iff (reset_btn)
        (!cmd_req && $past(!cmd_req)) |-> !cmd_ack)
    else begin
        $error("cmd_ack still high two cycles after cmd_req fell");
        n_ack_fall++;
    end

    // committed pose only moves inside an animation
    pose_chk: assert property (@(posedge clk_in) disable iff (reset_btn)
        !busy |-> $stable({cell_row, cell_col, heading}))
    else begin
        $error("pose changed while busy was low");
        n_pose++;
    end

    busy_chk: assert property (@(posedge clk_in) disable iff (reset_btn)
        cmd_ack |-> !busy)
    else begin
        $error("busy high while cmd_ack is high");
        n_busy++;
    end

endmodule

//--- maze_nav_top.sv
`timescale 1ns/1ps

module maze_nav_top import maze_pkg::*; #(
    parameter int        UNIT_SIZE = 64,
    parameter maze_map_t MAZE_MAP  = MAZE_DEFAULT
) (
    input  logic     clk_in,
    input  logic     reset_btn,
    input  logic     cmd_req,
    input  cmd_t     cmd,
    output logic     cmd_ack,
    output logic     cmd_accepted,
    output logic     busy,
    output cell_t    cell_row,
    output cell_t    cell_col,
    output heading_t heading,
    output coord_t   center_x,
    output coord_t   center_y,
    output angle_t   angle
);

    logic     launch;
    cmd_t     launch_kind;
    heading_t step_heading;
    logic     commit_reject;
    logic     anim_done;
    cmd_t     done_kind;
    logic     commit_done;

    // handshake and legality check
    cmd_decode #(
        .MAZE_MAP (MAZE_MAP)
    ) i_cmd_decode (
        .clk_in        (clk_in),
        .reset_btn     (reset_btn),
        .cmd_req       (cmd_req),
        .cmd           (cmd),
        .cell_row      (cell_row),
        .cell_col      (cell_col),
        .heading       (heading),
        .commit_done   (commit_done),
        .cmd_ack       (cmd_ack),
        .cmd_accepted  (cmd_accepted),
        .launch        (launch),
        .launch_kind   (launch_kind),
        .step_heading  (step_heading),
        .commit_reject (commit_reject)
    );

    // camera animation
    motion_animator #(
        .UNIT_SIZE (UNIT_SIZE)
    ) i_motion_animator (
        .clk_in       (clk_in),
        .reset_btn    (reset_btn),
        .launch       (launch),
        .launch_kind  (launch_kind),
        .step_heading (step_heading),
        .busy         (busy),
        .center_x     (center_x),
        .center_y     (center_y),
        .angle        (angle),
        .anim_done    (anim_done),
        .done_kind    (done_kind)
    );

    // committed grid pose
    pose_commit i_pose_commit (
        .clk_in        (clk_in),
        .reset_btn     (reset_btn),
        .anim_done     (anim_done),
        .done_kind     (done_kind),
        .step_heading  (step_heading),
        .commit_reject (commit_reject),
        .cell_row      (cell_row),
        .cell_col      (cell_col),
        .heading       (heading),
        .commit_done   (commit_done)
    );

endmodule

//--- pose_commit.sv
`timescale 1ns/1ps

module pose_commit import maze_pkg::*; (
    input  logic     clk_in,
    input  logic     reset_btn,
    input  logic     anim_done,
    input  cmd_t     done_kind,
    input  heading_t step_heading,
    input  logic     commit_reject,
    output cell_t    cell_row,
    output cell_t    cell_col,
    output heading_t heading,
    output logic     commit_done
);

    heading_t heading_left;
    heading_t heading_right;

    // enum order is U, L, D, R so a left turn counts up
    assign heading_left  = heading_t'(heading + 2'd1);
    assign heading_right = heading_t'(heading - 2'd1);

    always_ff @(posedge clk_in or posedge reset_btn) begin
        if (reset_btn) begin
            cell_row    <= 3'd0;
            cell_col    <= 3'd0;
            heading     <= HEAD_U;
            commit_done <= 1'b0;
        end else begin
            // rejected commands finish here as well, with no pose change
            commit_done <= anim_done | commit_reject;
            if (anim_done) begin
                case (done_kind)
                    CMD_MOVE: begin
                        // target was checked against the map before launch
                        case (step_heading)
                            HEAD_U:  cell_row <= cell_row - 3'd1;
                            HEAD_D:  cell_row <= cell_row + 3'd1;
                            HEAD_L:  cell_col <= cell_col - 3'd1;
                            default: cell_col <= cell_col + 3'd1;
                        endcase
                    end
                    CMD_LEFT:  heading <= heading_left;
                    CMD_RIGHT: heading <= heading_right;
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- motion_animator.sv
`timescale 1ns/1ps

module motion_animator import maze_pkg::*; #(
    parameter int UNIT_SIZE = 64
) (
    input  logic     clk_in,
    input  logic     reset_btn,
    input  logic     launch,
    input  cmd_t     launch_kind,
    input  heading_t step_heading,
    output logic     busy,
    output coord_t   center_x,
    output coord_t   center_y,
    output angle_t   angle,
    output logic     anim_done,
    output cmd_t     done_kind
);

    localparam int     MAX_STEPS    = (UNIT_SIZE > TURN_STEPS) ? UNIT_SIZE : TURN_STEPS;
    localparam int     CNT_W        = $clog2(MAX_STEPS + 1);
    localparam angle_t ANGLE_LAST   = angle_t'(359);
    localparam coord_t CENTER_START = coord_t'(UNIT_SIZE / 2);

    logic             active;
    logic [CNT_W-1:0] steps_left;
    logic [CNT_W-1:0] steps_load;
    cmd_t             kind;
    logic             tail;
    logic             busy_q;

    // one step per sub-cell unit for a move, per degree for a turn
    assign steps_load = (launch_kind == CMD_MOVE) ? CNT_W'(UNIT_SIZE) : CNT_W'(TURN_STEPS);

    // busy spans the launch cycle up to the commit cycle
    assign busy      = busy_q | launch;
    assign done_kind = kind;

    always_ff @(posedge clk_in or posedge reset_btn) begin
        if (reset_btn) begin
            active     <= 1'b0;
            steps_left <= '0;
            kind       <= CMD_NONE;
            anim_done  <= 1'b0;
            tail       <= 1'b0;
            busy_q     <= 1'b0;
            center_x   <= CENTER_START;
            center_y   <= CENTER_START;
            angle      <= angle_t'(ANGLE_START);
        end else begin
            anim_done <= 1'b0;
            // pose commits while tail is high
            tail      <= anim_done;
            if (tail) begin
                busy_q <= 1'b0;
            end
            if (launch) begin
                active     <= 1'b1;
                busy_q     <= 1'b1;
                steps_left <= steps_load;
                kind       <= launch_kind;
            end else if (active) begin
                if (steps_left != '0) begin
                    steps_left <= steps_left - 1'b1;
                    case (kind)
                        CMD_MOVE: begin
                            // x follows rows, y follows columns
                            case (step_heading)
                                HEAD_U:  center_x <= center_x - coord_t'(1);
                                HEAD_D:  center_x <= center_x + coord_t'(1);
                                HEAD_L:  center_y <= center_y - coord_t'(1);
                                default: center_y <= center_y + coord_t'(1);
                            endcase
                        end
                        CMD_LEFT: begin
                            if (angle == 9'd0) begin
                                angle <= ANGLE_LAST;
                            end else begin
                                angle <= angle - 9'd1;
                            end
                        end
                        CMD_RIGHT: begin
                            if (angle == ANGLE_LAST) begin
                                angle <= 9'd0;
                            end else begin
                                angle <= angle + 9'd1;
                            end
                        end
                        default: ;
                    endcase
                end else begin
                    // last step went out on the previous edge
                    active    <= 1'b0;
                    anim_done <= 1'b1;
                end
            end
        end
    end

endmodule

//--- cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode import maze_pkg::*; #(
    parameter maze_map_t MAZE_MAP = MAZE_DEFAULT
) (
    input  logic     clk_in,
    input  logic     reset_btn,
    input  logic     cmd_req,
    input  cmd_t     cmd,
    input  cell_t    cell_row,
    input  cell_t    cell_col,
    input  heading_t heading,
    input  logic     commit_done,
    output logic     cmd_ack,
    output logic     cmd_accepted,
    output logic     launch,
    output cmd_t     launch_kind,
    output heading_t step_heading,
    output logic     commit_reject
);

    decode_state_t state;
    logic          in_grid;
    cell_t         tgt_row;
    cell_t         tgt_col;
    logic [4:0]    map_idx;
    logic          blocked;
    logic          legal;

    // neighbour cell in the heading direction
    always_comb begin
        tgt_row = cell_row;
        tgt_col = cell_col;
        in_grid = 1'b1;
        case (heading)
            HEAD_U: begin
                in_grid = (cell_row != 3'd0);
                tgt_row = cell_row - 3'd1;
            end
            HEAD_D: begin
                in_grid = (cell_row < cell_t'(GRID_DIM - 1));
                tgt_row = cell_row + 3'd1;
            end
            HEAD_L: begin
                in_grid = (cell_col != 3'd0);
                tgt_col = cell_col - 3'd1;
            end
            default: begin
                in_grid = (cell_col < cell_t'(GRID_DIM - 1));
                tgt_col = cell_col + 3'd1;
            end
        endcase
    end

    // leaving the grid counts as hitting a wall
    assign map_idx = 5'(tgt_row * GRID_DIM + tgt_col);
    assign blocked = in_grid ? MAZE_MAP[map_idx] : 1'b1;

    always_comb begin
        case (cmd)
            CMD_MOVE:            legal = !blocked;
            CMD_LEFT, CMD_RIGHT: legal = 1'b1;
            default:             legal = 1'b0;
        endcase
    end

    always_ff @(posedge clk_in or posedge reset_btn) begin
        if (reset_btn) begin
            state         <= DEC_IDLE;
            cmd_ack       <= 1'b0;
            cmd_accepted  <= 1'b0;
            launch        <= 1'b0;
            commit_reject <= 1'b0;
            launch_kind   <= CMD_NONE;
            step_heading  <= HEAD_U;
        end else begin
            launch        <= 1'b0;
            commit_reject <= 1'b0;
            case (state)
                DEC_IDLE: begin
                    if (cmd_req) begin
                        launch_kind   <= cmd;
                        step_heading  <= heading;
                        cmd_accepted  <= legal;
                        launch        <= legal;
                        commit_reject <= !legal;
                        state         <= DEC_BUSY;
                    end
                end
                DEC_BUSY: begin
                    if (commit_done) begin
                        cmd_ack <= 1'b1;
                        state   <= DEC_ACK;
                    end
                end
                DEC_ACK: begin
                    // hold the response until the request is withdrawn
                    if (!cmd_req) begin
                        cmd_ack      <= 1'b0;
                        cmd_accepted <= 1'b0;
                        state        <= DEC_IDLE;
                    end
                end
                default: state <= DEC_IDLE;
            endcase
        end
    end

endmodule

//--- maze_pkg.sv
package maze_pkg;

    // rows and columns of the square maze
    localparam int GRID_DIM = 5;

    // one quarter turn in one-degree steps
    localparam int TURN_STEPS = 90;

    // view angle after reset, in degrees
    localparam int ANGLE_START = 180;

    // grid row or column index
    typedef logic [2:0] cell_t;

    // camera centre on one axis, sub-cell units
    typedef logic signed [9:0] coord_t;

    // view angle, 0 to 359 degrees
    typedef logic [8:0] angle_t;

    // wall map, bit r*GRID_DIM+c set where cell (r, c) is blocked
    typedef logic [GRID_DIM*GRID_DIM-1:0] maze_map_t;

    // rows from 4 down to 0, leftmost digit of each row is column 4
    localparam maze_map_t MAZE_DEFAULT = {
        5'b01000,
        5'b01010,
        5'b01010,
        5'b01010,
        5'b00010
    };

    // left turn walks U, L, D, R, right turn walks back
    typedef enum logic [1:0] {
        HEAD_U,
        HEAD_L,
        HEAD_D,
        HEAD_R
    } heading_t;

    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_MOVE,
        CMD_LEFT,
        CMD_RIGHT
    } cmd_t;

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_BUSY,
        DEC_ACK
    } decode_state_t;

endpackage
